// File: hdl/mpram_pkg.sv
package mpram_pkg;

   localparam int data_w = 8;
   localparam int addr_w = 5;

   // only 24 of the 32 addresses are backed by storage.
   localparam int depth = 24;

   localparam int num_rd = 4;
   localparam int num_wr = 2;

   localparam int cnt_w = 8; // error counters saturate at the top of this range.

   // write request as presented on each write port.
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
   } wr_req_t;

   typedef struct packed {
      logic [addr_w-1:0] addr;
   } rd_req_t;

   // read response, held in the read port until it is taken.
   typedef struct packed {
      logic [data_w-1:0] data;
      logic              addr_err;     // address was 24 or above.
      logic              powered_down; // data is all ones.
   } rd_rsp_t;

   // array write command after range check and collision handling.
   typedef struct packed {
      logic              en;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
   } wr_cmd_t;

   typedef struct packed {
      logic [cnt_w-1:0] rd_err_cnt;
      logic [cnt_w-1:0] wr_err_cnt;
      logic [cnt_w-1:0] collision_cnt;
      logic             rd_err_seen;
      logic             wr_err_seen;
      logic             collision_seen;
   } err_status_t;

endpackage

// File: hdl/mpram_storage_array.sv
`timescale 1ns/1ps

module mpram_storage_array
(
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  mpram_pkg::wr_cmd_t [mpram_pkg::num_wr-1:0]           wr_cmd,
   input  logic [mpram_pkg::num_rd-1:0][mpram_pkg::addr_w-1:0] rd_addr,
   output logic [mpram_pkg::num_rd-1:0][mpram_pkg::data_w-1:0] rd_data
);

   logic [mpram_pkg::data_w-1:0] mem [mpram_pkg::depth];

   // the write commands are applied in port order so that port 1 lands last.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < mpram_pkg::depth; i++)
         begin
            mem[i] <= '0;
         end
      end
      else
      begin
         for (int p = 0; p < mpram_pkg::num_wr; p++)
         begin
            if (wr_cmd[p].en)
            begin
               mem[wr_cmd[p].addr] <= wr_cmd[p].data;
            end
         end
      end
   end

   // read taps see the contents as they were before the current edge.
   always_comb
   begin
      for (int r = 0; r < mpram_pkg::num_rd; r++)
      begin
         if (rd_addr[r] < mpram_pkg::depth)
         begin
            rd_data[r] = mem[rd_addr[r]];
         end
         else
         begin
            rd_data[r] = '0; // no storage behind these addresses.
         end
      end
   end

endmodule

// File: hdl/mpram_write_arbiter.sv
`timescale 1ns/1ps

module mpram_write_arbiter
(
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       pd_n,
   input  logic [mpram_pkg::num_wr-1:0]               wr_valid,
   input  mpram_pkg::wr_req_t [mpram_pkg::num_wr-1:0] wr_req,
   output logic [mpram_pkg::num_wr-1:0]               wr_ready,
   output mpram_pkg::wr_cmd_t [mpram_pkg::num_wr-1:0] wr_cmd,
   output logic [mpram_pkg::num_wr-1:0]               wr_err,
   output logic                                       collision
);

   logic                         en_q;
   logic [mpram_pkg::num_wr-1:0] accept;
   logic [mpram_pkg::num_wr-1:0] in_range;

   // writes are refused until the first edge after reset.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         en_q <= 1'b0;
      end
      else
      begin
         en_q <= 1'b1;
      end
   end

   assign wr_ready = {mpram_pkg::num_wr{en_q & pd_n}}; // power-down stalls both writers.

   always_comb
   begin
      for (int p = 0; p < mpram_pkg::num_wr; p++)
      begin
         accept[p]   = wr_valid[p] & wr_ready[p];
         in_range[p] = wr_req[p].addr < mpram_pkg::depth;
         wr_err[p]   = accept[p] & ~in_range[p];
      end

      // both writers landing on the same real word in one cycle.
      collision = (&accept) & (&in_range) & (wr_req[0].addr == wr_req[1].addr);

      for (int p = 0; p < mpram_pkg::num_wr; p++)
      begin
         wr_cmd[p].en   = accept[p] & in_range[p]; // out-of-range writes are dropped.
         wr_cmd[p].addr = wr_req[p].addr;
         wr_cmd[p].data = wr_req[p].data;
      end

      // port 1 wins a collision, so the port 0 write is not issued.
      if (collision)
      begin
         wr_cmd[0].en = 1'b0;
      end
   end

endmodule

// File: hdl/mpram_read_port.sv
`timescale 1ns/1ps

module mpram_read_port
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          pd_n,
   input  logic                          rd_valid,
   input  mpram_pkg::rd_req_t            rd_req,
   input  logic                          rsp_ready,
   input  logic [mpram_pkg::data_w-1:0]  tap_data,
   output logic                          rd_ready,
   output logic [mpram_pkg::addr_w-1:0]  tap_addr,
   output logic                          rsp_valid,
   output mpram_pkg::rd_rsp_t            rd_rsp,
   output logic                          rd_err
);

   logic               active_q; // low until the first edge after reset.
   logic               accept;
   logic               addr_bad;
   mpram_pkg::rd_rsp_t rsp_next;

   assign tap_addr = rd_req.addr;

   // the response register can take a new entry when it is empty or draining.
   assign rd_ready = active_q & (~rsp_valid | rsp_ready);
   assign accept   = rd_valid & rd_ready;
   assign addr_bad = rd_req.addr >= mpram_pkg::depth;

   // no address check while powered down.
   assign rd_err = accept & pd_n & addr_bad;

   always_comb
   begin
      rsp_next = '0;
      if (!pd_n)
      begin
         rsp_next.data         = '1;
         rsp_next.powered_down = 1'b1;
      end
      else if (addr_bad)
      begin
         rsp_next.addr_err = 1'b1; // data stays zero.
      end
      else
      begin
         rsp_next.data = tap_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active_q  <= 1'b0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         active_q <= 1'b1;
         if (accept)
         begin
            rsp_valid <= 1'b1;
         end
         else if (rsp_ready)
         begin
            rsp_valid <= 1'b0;
         end
      end
   end

   // a stalled response holds here until rsp_ready returns.
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         rd_rsp <= rsp_next;
      end
   end

endmodule

// File: hdl/mpram_error_log.sv
`timescale 1ns/1ps

module mpram_error_log
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [mpram_pkg::num_rd-1:0] rd_err,
   input  logic [mpram_pkg::num_wr-1:0] wr_err,
   input  logic                         collision,
   output mpram_pkg::err_status_t       err_status
);

   logic [2:0] rd_inc;
   logic [2:0] wr_inc;
   logic [2:0] col_inc;

   // adds one cycle's pulses to a counter and holds it at all ones.
   function automatic logic [mpram_pkg::cnt_w-1:0] sat_add
   (
      input logic [mpram_pkg::cnt_w-1:0] cnt,
      input logic [2:0]                  inc
   );
      logic [mpram_pkg::cnt_w:0] sum;
      sum = {1'b0, cnt} + {{(mpram_pkg::cnt_w - 2){1'b0}}, inc};
      return sum[mpram_pkg::cnt_w] ? '1 : sum[mpram_pkg::cnt_w-1:0];
   endfunction

   assign rd_inc  = 3'($countones(rd_err)); // up to four read errors per cycle.
   assign wr_inc  = 3'($countones(wr_err));
   assign col_inc = {2'b00, collision};

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         err_status <= '0;
      end
      else
      begin
         err_status.rd_err_cnt     <= sat_add(err_status.rd_err_cnt, rd_inc);
         err_status.wr_err_cnt     <= sat_add(err_status.wr_err_cnt, wr_inc);
         err_status.collision_cnt  <= sat_add(err_status.collision_cnt, col_inc);
         err_status.rd_err_seen    <= err_status.rd_err_seen | (|rd_err);
         err_status.wr_err_seen    <= err_status.wr_err_seen | (|wr_err);
         err_status.collision_seen <= err_status.collision_seen | collision;
      end
   end

endmodule

// File: hdl/mpram_4r2w_top.sv
`timescale 1ns/1ps

module mpram_4r2w_top
(
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       pd_n, // low means powered down.

   input  logic [mpram_pkg::num_wr-1:0]               wr_valid,
   output logic [mpram_pkg::num_wr-1:0]               wr_ready,
   input  mpram_pkg::wr_req_t [mpram_pkg::num_wr-1:0] wr_req,

   input  logic [mpram_pkg::num_rd-1:0]               rd_valid,
   output logic [mpram_pkg::num_rd-1:0]               rd_ready,
   input  mpram_pkg::rd_req_t [mpram_pkg::num_rd-1:0] rd_req,

   output logic [mpram_pkg::num_rd-1:0]               rsp_valid,
   input  logic [mpram_pkg::num_rd-1:0]               rsp_ready,
   output mpram_pkg::rd_rsp_t [mpram_pkg::num_rd-1:0] rd_rsp,

   output mpram_pkg::err_status_t                     err_status
);

   mpram_pkg::wr_cmd_t [mpram_pkg::num_wr-1:0]           wr_cmd;
   logic [mpram_pkg::num_wr-1:0]                         wr_err;
   logic                                                 collision;
   logic [mpram_pkg::num_rd-1:0][mpram_pkg::addr_w-1:0] tap_addr;
   logic [mpram_pkg::num_rd-1:0][mpram_pkg::data_w-1:0] tap_data;
   logic [mpram_pkg::num_rd-1:0]                         rd_err;

   mpram_storage_array i_storage_array
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_cmd  (wr_cmd),
      .rd_addr (tap_addr),
      .rd_data (tap_data)
   );

   mpram_write_arbiter i_write_arbiter
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .pd_n      (pd_n),
      .wr_valid  (wr_valid),
      .wr_req    (wr_req),
      .wr_ready  (wr_ready),
      .wr_cmd    (wr_cmd),
      .wr_err    (wr_err),
      .collision (collision)
   );

   // one read port per array tap.
   for (genvar g = 0; g < mpram_pkg::num_rd; g++)
   begin : g_read_port
      mpram_read_port i_read_port
      (
         .clk       (clk),
         .rst_n     (rst_n),
         .pd_n      (pd_n),
         .rd_valid  (rd_valid[g]),
         .rd_req    (rd_req[g]),
         .rsp_ready (rsp_ready[g]),
         .tap_data  (tap_data[g]),
         .rd_ready  (rd_ready[g]),
         .tap_addr  (tap_addr[g]),
         .rsp_valid (rsp_valid[g]),
         .rd_rsp    (rd_rsp[g]),
         .rd_err    (rd_err[g])
      );
   end

   mpram_error_log i_error_log
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .rd_err     (rd_err),
      .wr_err     (wr_err),
      .collision  (collision),
      .err_status (err_status)
   );

endmodule

// File: dv/mpram_tb_table.svh
`ifndef MPRAM_TB_TABLE_SVH
`define MPRAM_TB_TABLE_SVH

// the columns are wr_valid, wr addr/data port 0, wr addr/data port 1, rd_valid, rd addresses,
// then rsp_ready, pd_n, and the response expected one cycle later (valid, data, addr_err, pd).
// per-port lists run from port 3 down to port 0.
typedef struct packed {
   logic [1:0]  wr_valid;
   logic [4:0]  wa0;
   logic [7:0]  wd0;
   logic [4:0]  wa1;
   logic [7:0]  wd1;
   logic [3:0]  rd_valid;
   logic [19:0] ra;
   logic [3:0]  rsp_ready;
   logic        pd_n;
   logic [3:0]  exp_valid;
   logic [31:0] exp_data;
   logic [3:0]  exp_ae;
   logic [3:0]  exp_pd;
} dir_row_t;

localparam int num_rows = 14;

dir_row_t dir_rows [num_rows] = '{
   '{2'b11, 5'd3,  8'h11, 5'd5,  8'h22, 4'h0, {5'd0,  5'd0,  5'd0,  5'd0},
     4'hf, 1'b1, 4'h0, 32'h0000_0000, 4'h0, 4'h0},
   '{2'b10, 5'd0,  8'h00, 5'd7,  8'h33, 4'hf, {5'd5,  5'd3,  5'd5,  5'd3},
     4'hf, 1'b1, 4'hf, 32'h2211_2211, 4'h0, 4'h0},
   '{2'b11, 5'd9,  8'haa, 5'd9,  8'hbb, 4'hf, {5'd7,  5'd7,  5'd7,  5'd7},
     4'hf, 1'b1, 4'hf, 32'h3333_3333, 4'h0, 4'h0},
   '{2'b11, 5'd25, 8'h44, 5'd24, 8'h55, 4'hf, {5'd9,  5'd9,  5'd9,  5'd9},
     4'hf, 1'b1, 4'hf, 32'hbbbb_bbbb, 4'h0, 4'h0},
   '{2'b00, 5'd0,  8'h00, 5'd0,  8'h00, 4'hf, {5'd24, 5'd31, 5'd9,  5'd0},
     4'hf, 1'b1, 4'hf, 32'h0000_bb00, 4'hc, 4'h0},
   '{2'b01, 5'd3,  8'hee, 5'd0,  8'h00, 4'hf, {5'd7,  5'd5,  5'd25, 5'd3},
     4'hf, 1'b0, 4'hf, 32'hffff_ffff, 4'h0, 4'hf},
   '{2'b01, 5'd3,  8'hee, 5'd0,  8'h00, 4'h0, {5'd0,  5'd0,  5'd0,  5'd0},
     4'hf, 1'b0, 4'h0, 32'h0000_0000, 4'h0, 4'h0},
   '{2'b01, 5'd3,  8'hee, 5'd0,  8'h00, 4'h0, {5'd0,  5'd0,  5'd0,  5'd0},
     4'hf, 1'b1, 4'h0, 32'h0000_0000, 4'h0, 4'h0},
   '{2'b00, 5'd0,  8'h00, 5'd0,  8'h00, 4'hf, {5'd3,  5'd9,  5'd7,  5'd5},
     4'hf, 1'b1, 4'hf, 32'heebb_3322, 4'h0, 4'h0},
   '{2'b00, 5'd0,  8'h00, 5'd0,  8'h00, 4'hf, {5'd3,  5'd3,  5'd3,  5'd3},
     4'hf, 1'b1, 4'hf, 32'heeee_eeee, 4'h0, 4'h0},
   '{2'b00, 5'd0,  8'h00, 5'd0,  8'h00, 4'hf, {5'd7,  5'd7,  5'd7,  5'd7},
     4'h0, 1'b1, 4'hf, 32'heeee_eeee, 4'h0, 4'h0},
   '{2'b00, 5'd0,  8'h00, 5'd0,  8'h00, 4'hf, {5'd7,  5'd7,  5'd7,  5'd7},
     4'h0, 1'b1, 4'hf, 32'heeee_eeee, 4'h0, 4'h0},
   '{2'b00, 5'd0,  8'h00, 5'd0,  8'h00, 4'hf, {5'd7,  5'd7,  5'd7,  5'd7},
     4'hf, 1'b1, 4'hf, 32'h3333_3333, 4'h0, 4'h0},
   '{2'b00, 5'd0,  8'h00, 5'd0,  8'h00, 4'h0, {5'd0,  5'd0,  5'd0,  5'd0},
     4'hf, 1'b1, 4'h0, 32'h0000_0000, 4'h0, 4'h0}
};

`endif

// File: dv/mpram_4r2w_tb.sv
`timescale 1ns/1ps

module mpram_4r2w_tb;

   `include "mpram_tb_table.svh"

   localparam int clk_period     = 100;
   localparam int rand_cycles    = 300;
   localparam int timeout_cycles = num_rows + rand_cycles + 50;

   logic                                       clk;
   logic                                       rst_n;
   logic                                       pd_n;
   logic [mpram_pkg::num_wr-1:0]               wr_valid;
   logic [mpram_pkg::num_wr-1:0]               wr_ready;
   mpram_pkg::wr_req_t [mpram_pkg::num_wr-1:0] wr_req;
   logic [mpram_pkg::num_rd-1:0]               rd_valid;
   logic [mpram_pkg::num_rd-1:0]               rd_ready;
   mpram_pkg::rd_req_t [mpram_pkg::num_rd-1:0] rd_req;
   logic [mpram_pkg::num_rd-1:0]               rsp_valid;
   logic [mpram_pkg::num_rd-1:0]               rsp_ready;
   mpram_pkg::rd_rsp_t [mpram_pkg::num_rd-1:0] rd_rsp;
   mpram_pkg::err_status_t                     err_status;

   // reference model of the memory, the response registers and the error log.
   logic [mpram_pkg::data_w-1:0] m_mem [mpram_pkg::depth];
   logic [mpram_pkg::num_rd-1:0] m_valid;
   mpram_pkg::rd_rsp_t           m_rsp [mpram_pkg::num_rd];
   mpram_pkg::err_status_t       m_status;
   logic [mpram_pkg::num_wr-1:0] w_acc; // acceptances seen by the model this cycle.
   logic [mpram_pkg::num_rd-1:0] r_acc;

   int checks;
   int errors;

   mpram_4r2w_top i_dut
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .pd_n       (pd_n),
      .wr_valid   (wr_valid),
      .wr_ready   (wr_ready),
      .wr_req     (wr_req),
      .rd_valid   (rd_valid),
      .rd_ready   (rd_ready),
      .rd_req     (rd_req),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rd_rsp     (rd_rsp),
      .err_status (err_status)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   function automatic logic [mpram_pkg::cnt_w-1:0] capped_count(input int value);
      return (value > 255) ? 8'hff : value[mpram_pkg::cnt_w-1:0];
   endfunction

   task automatic end_test(input string name, input int c0, input int e0);
      $display("test %s finished: %0d checks, %0d errors", name, checks - c0, errors - e0);
   endtask

   // compares the registered outputs and the readies with the model.
   task automatic compare_outputs();
      for (int p = 0; p < mpram_pkg::num_rd; p++)
      begin
         check_value(rsp_valid[p], m_valid[p], $sformatf("rsp_valid of port %0d", p));
         check_value(rd_ready[p], !m_valid[p] || rsp_ready[p],
                     $sformatf("rd_ready of port %0d", p));
         if (m_valid[p])
         begin
            check_value(rd_rsp[p], m_rsp[p], $sformatf("rd_rsp of port %0d", p));
         end
      end
      check_value(wr_ready, {mpram_pkg::num_wr{pd_n}}, "wr_ready");
      check_value(err_status, m_status, "err_status");
   endtask

   task automatic check_row(input dir_row_t r, input int idx);
      for (int p = 0; p < mpram_pkg::num_rd; p++)
      begin
         check_value(rsp_valid[p], r.exp_valid[p], $sformatf("row %0d valid port %0d", idx, p));
         if (r.exp_valid[p])
         begin
            check_value(rd_rsp[p], {r.exp_data[p*8 +: 8], r.exp_ae[p], r.exp_pd[p]},
                        $sformatf("row %0d response port %0d", idx, p));
         end
      end
   endtask

   task automatic step_model();
      int                           rd_inc;
      int                           wr_inc;
      int                           col_inc;
      mpram_pkg::rd_rsp_t           nr;
      logic [mpram_pkg::num_wr-1:0] in_range;
      rd_inc  = 0;
      wr_inc  = 0;
      col_inc = 0;
      for (int p = 0; p < mpram_pkg::num_rd; p++)
      begin
         r_acc[p] = rd_valid[p] && (!m_valid[p] || rsp_ready[p]);
         if (r_acc[p])
         begin
            nr = '0;
            if (!pd_n)
            begin
               nr.data         = '1;
               nr.powered_down = 1'b1;
            end
            else if (rd_req[p].addr >= mpram_pkg::depth)
            begin
               nr.addr_err = 1'b1;
               rd_inc++;
            end
            else
            begin
               nr.data = m_mem[rd_req[p].addr];
            end
            m_rsp[p]   = nr;
            m_valid[p] = 1'b1;
         end
         else if (rsp_ready[p])
         begin
            m_valid[p] = 1'b0;
         end
      end
      // writes go in after the reads, which see the old contents.
      for (int i = 0; i < mpram_pkg::num_wr; i++)
      begin
         w_acc[i]    = wr_valid[i] && pd_n;
         in_range[i] = wr_req[i].addr < mpram_pkg::depth;
         wr_inc     += (w_acc[i] && !in_range[i]) ? 1 : 0;
      end
      if (&w_acc && &in_range && wr_req[0].addr == wr_req[1].addr)
      begin
         col_inc = 1;
         m_mem[wr_req[1].addr] = wr_req[1].data;
      end
      else
      begin
         for (int i = 0; i < mpram_pkg::num_wr; i++)
         begin
            if (w_acc[i] && in_range[i])
            begin
               m_mem[wr_req[i].addr] = wr_req[i].data;
            end
         end
      end
      m_status.rd_err_cnt     = capped_count(m_status.rd_err_cnt + rd_inc);
      m_status.wr_err_cnt     = capped_count(m_status.wr_err_cnt + wr_inc);
      m_status.collision_cnt  = capped_count(m_status.collision_cnt + col_inc);
      m_status.rd_err_seen    = m_status.rd_err_seen || rd_inc > 0;
      m_status.wr_err_seen    = m_status.wr_err_seen || wr_inc > 0;
      m_status.collision_seen = m_status.collision_seen || col_inc > 0;
   endtask

   task automatic apply_row(input dir_row_t r);
      wr_valid  <= r.wr_valid;
      wr_req[0] <= {r.wa0, r.wd0};
      wr_req[1] <= {r.wa1, r.wd1};
      rd_valid  <= r.rd_valid;
      rd_req    <= r.ra;
      rsp_ready <= r.rsp_ready;
      pd_n      <= r.pd_n;
   endtask

   // pending requests stay up until they are taken.
   task automatic drive_idle();
      wr_valid  <= wr_valid & ~w_acc;
      rd_valid  <= rd_valid & ~r_acc;
      rsp_ready <= '1;
      pd_n      <= 1'b1;
   endtask

   // a request that was not accepted keeps its valid and payload.
   task automatic drive_random();
      mpram_pkg::wr_req_t           wnew [mpram_pkg::num_wr];
      logic [mpram_pkg::num_wr-1:0] fresh;
      for (int i = 0; i < mpram_pkg::num_wr; i++)
      begin
         fresh[i]     = !(wr_valid[i] && !w_acc[i]);
         wnew[i].addr = 5'($urandom);
         wnew[i].data = 8'($urandom);
      end
      if (&fresh && ($urandom % 4) == 0)
      begin
         wnew[1].addr = wnew[0].addr; // steer some cycles into a collision.
      end
      for (int i = 0; i < mpram_pkg::num_wr; i++)
      begin
         if (fresh[i])
         begin
            wr_valid[i] <= 1'($urandom);
            wr_req[i]   <= wnew[i];
         end
      end
      for (int p = 0; p < mpram_pkg::num_rd; p++)
      begin
         if (!(rd_valid[p] && !r_acc[p]))
         begin
            rd_valid[p] <= ($urandom % 8) < 5;
            rd_req[p]   <= 5'($urandom);
         end
         rsp_ready[p] <= ($urandom % 4) != 0;
      end
      pd_n <= ($urandom % 16) != 0;
   endtask

   initial
   begin
      int c0;
      int e0;
      checks    = 0;
      errors    = 0;
      void'($urandom(32'h99b7_3560));
      clk       = 1'b0;
      rst_n     = 1'b0;
      pd_n      = 1'b1;
      wr_valid  = '0;
      wr_req    = '0;
      rd_valid  = '0;
      rd_req    = '0;
      rsp_ready = '1;
      m_valid   = '0;
      m_status  = '0;
      w_acc     = '0;
      r_acc     = '0;
      for (int a = 0; a < mpram_pkg::depth; a++)
      begin
         m_mem[a] = '0;
      end

      c0 = checks;
      e0 = errors;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk); // readies stay low until the next edge.
      check_value(wr_ready, '0, "wr_ready right after reset");
      check_value(rd_ready, '0, "rd_ready right after reset");
      check_value(rsp_valid, '0, "rsp_valid right after reset");
      check_value(err_status, '0, "err_status right after reset");
      end_test("reset", c0, e0);

      c0 = checks;
      e0 = errors;
      for (int i = 0; i <= num_rows; i++)
      begin
         @(posedge clk);
         if (i < num_rows)
         begin
            apply_row(dir_rows[i]);
         end
         else
         begin
            drive_idle();
         end
         @(negedge clk);
         compare_outputs();
         if (i > 0)
         begin
            check_row(dir_rows[i-1], i - 1);
         end
         step_model();
      end
      end_test("directed", c0, e0);

      c0 = checks;
      e0 = errors;
      for (int n = 0; n <= rand_cycles; n++)
      begin
         @(posedge clk);
         if (n < rand_cycles)
         begin
            drive_random();
         end
         else
         begin
            drive_idle();
         end
         @(negedge clk);
         compare_outputs();
         step_model();
      end
      end_test("random", c0, e0);

      c0 = checks;
      e0 = errors;
      @(negedge clk);
      check_value(err_status, m_status, "final err_status");
      end_test("final status", c0, e0);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("All checks passed");
      end
      else
      begin
         $display("Checks failed");
      end
      $finish;
   end

   initial
   begin
      #(timeout_cycles * clk_period);
      $display("The run timed out after %0d clock periods.", timeout_cycles);
      $display("Checks failed");
      $finish;
   end

endmodule

// File: mpram_4r2w_top.f
+incdir+dv
hdl/mpram_pkg.sv
hdl/mpram_storage_array.sv
hdl/mpram_write_arbiter.sv
hdl/mpram_read_port.sv
hdl/mpram_error_log.sv
hdl/mpram_4r2w_top.sv
dv/mpram_4r2w_tb.sv
